// File: verilog/dcache_pkg.sv
package dcache_pkg;

    localparam int SET_NUM  = 16;
    localparam int WAY_NUM  = 2;
    localparam int OFFSET_W = 3;
    localparam int INDEX_W  = 4;
    localparam int TAG_W    = 32 - INDEX_W - OFFSET_W;

    typedef logic [31:0]         addr_t;
    typedef logic [31:0]         word_t;
    typedef logic [63:0]         line_t;
    typedef logic [TAG_W-1:0]    tag_t;
    typedef logic [INDEX_W-1:0]  set_idx_t;
    typedef logic [OFFSET_W-1:0] offset_t;
    // zero means no transaction
    typedef logic [3:0]          mem_tag_t;
    typedef logic [3:0]          lsq_tag_t;

    typedef enum logic [1:0] {
        BYTE = 2'h0,
        HALF = 2'h1,
        WORD = 2'h2
    } mem_size_t;

    typedef enum logic [1:0] {
        CMD_NONE  = 2'h0,
        CMD_LOAD  = 2'h1,
        CMD_STORE = 2'h2
    } mem_cmd_t;

    typedef enum logic [1:0] {
        MSHR_INVALID = 2'h0,
        MSHR_WAITING = 2'h1,
        MSHR_READY   = 2'h2
    } mshr_state_t;

    typedef struct packed {
        logic      valid;
        addr_t     address;
        logic      is_load;
        mem_size_t size;
        logic      is_unsigned;
        word_t     value;
        lsq_tag_t  lsq_tag;
    } lsq_req_t;

    typedef struct packed {
        logic     valid;
        addr_t    address;
        logic     is_load;
        word_t    value;
        lsq_tag_t lsq_tag;
    } lsq_resp_t;

    typedef struct packed {
        logic  valid;
        tag_t  tag;
        line_t data;
    } cache_line_t;

    // lru names the way used last
    typedef struct packed {
        cache_line_t [WAY_NUM-1:0] way;
        logic                      lru;
    } cache_set_t;

    typedef struct packed {
        logic     valid;
        set_idx_t index;
        tag_t     tag;
        line_t    data;
    } fill_t;

    typedef struct packed {
        logic  valid;
        addr_t address;
        line_t data;
    } victim_t;

    typedef struct packed {
        mem_cmd_t command;
        addr_t    address;
        line_t    data;
    } mem_req_t;

    typedef struct packed {
        mem_tag_t response;
        mem_tag_t tag;
        line_t    data;
    } mem_resp_t;

    function automatic line_t store_merge(line_t line, word_t value, mem_size_t size,
                                          offset_t offset);
        line_t merged;
        merged = line;
        case (size)
            BYTE:    merged[{offset, 3'b000} +: 8] = value[7:0];
            HALF:    merged[{offset[2:1], 4'h0} +: 16] = value[15:0];
            default: merged[{offset[2], 5'h00} +: 32] = value;
        endcase
        return merged;
    endfunction

    function automatic word_t load_extract(line_t line, mem_size_t size, offset_t offset,
                                           logic is_unsigned);
        word_t word;
        word_t result;
        word = offset[2] ? line[63:32] : line[31:0];
        case (size)
            BYTE: begin
                result = word >> {offset[1:0], 3'b000};
                result[31:8] = is_unsigned ? 24'h0 : {24{result[7]}};
            end
            HALF: begin
                result = word >> {offset[1], 4'h0};
                result[31:16] = is_unsigned ? 16'h0 : {16{result[15]}};
            end
            default: result = word;
        endcase
        return result;
    endfunction

endpackage

// File: verilog/dcache_lookup.sv
`timescale 1ns/100ps

module dcache_lookup (
    input  dcache_pkg::lsq_req_t   req,
    input  dcache_pkg::cache_set_t set_data,
    output dcache_pkg::set_idx_t   index,
    output logic                   hit,
    output logic                   hit_way,
    output logic                   miss
);

    dcache_pkg::tag_t               req_tag;
    logic [dcache_pkg::WAY_NUM-1:0] way_hit;

    // offset bits only matter to the lane logic downstream
    assign {req_tag, index} = req.address[31:dcache_pkg::OFFSET_W];

    always_comb begin
        for (int w = 0; w < dcache_pkg::WAY_NUM; w++) begin
            way_hit[w] = req.valid && set_data.way[w].valid
                         && (set_data.way[w].tag == req_tag);
        end
    end

    assign hit     = |way_hit;
    assign hit_way = way_hit[1];
    assign miss    = req.valid && !hit;

    // fills never place a line twice in one set
    always_comb begin
        a_single_way_hit: assert final ($onehot0(way_hit));
    end

endmodule

// File: verilog/dcache_array.sv
`timescale 1ns/100ps

module dcache_array (
    input  logic                   clock,
    input  logic                   reset,
    input  dcache_pkg::lsq_req_t   req,
    input  dcache_pkg::set_idx_t   index,
    input  logic                   hit,
    input  logic                   hit_way,
    input  dcache_pkg::fill_t      fill,
    output dcache_pkg::cache_set_t set_data,
    output dcache_pkg::victim_t    victim,
    input  logic                   victim_taken
);

    logic [dcache_pkg::WAY_NUM-1:0] valid_q [dcache_pkg::SET_NUM];
    logic                           lru_q   [dcache_pkg::SET_NUM];
    dcache_pkg::tag_t               tag_q   [dcache_pkg::SET_NUM][dcache_pkg::WAY_NUM];
    dcache_pkg::line_t              data_q  [dcache_pkg::SET_NUM][dcache_pkg::WAY_NUM];
    logic                           fill_way;

    // a hit in the filled set keeps its own way
    assign fill_way = (hit && index == fill.index) ? !hit_way : !lru_q[fill.index];

    always_comb begin
        for (int w = 0; w < dcache_pkg::WAY_NUM; w++) begin
            set_data.way[w].valid = valid_q[index][w];
            set_data.way[w].tag   = tag_q[index][w];
            set_data.way[w].data  = data_q[index][w];
        end
        set_data.lru = lru_q[index];
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int s = 0; s < dcache_pkg::SET_NUM; s++) begin
                valid_q[s] <= '0;
                lru_q[s]   <= 1'b0;
            end
        end else begin
            if (hit) begin
                lru_q[index] <= hit_way;
            end
            // fill wins the lru when both touch one set
            if (fill.valid) begin
                valid_q[fill.index][fill_way] <= 1'b1;
                lru_q[fill.index]             <= fill_way;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (hit && !req.is_load) begin
            data_q[index][hit_way] <= dcache_pkg::store_merge(data_q[index][hit_way],
                                                              req.value, req.size,
                                                              req.address[2:0]);
        end
        if (fill.valid) begin
            tag_q[fill.index][fill_way]  <= fill.tag;
            data_q[fill.index][fill_way] <= fill.data;
        end
    end

    // victim held until the memory port sends it
    always_ff @(posedge clock) begin
        if (reset) begin
            victim.valid <= 1'b0;
        end else if (fill.valid && valid_q[fill.index][fill_way]) begin
            victim.valid   <= 1'b1;
            victim.address <= {tag_q[fill.index][fill_way], fill.index, 3'b000};
            victim.data    <= data_q[fill.index][fill_way];
        end else if (victim_taken) begin
            victim.valid <= 1'b0;
        end
    end

endmodule

// File: verilog/dcache_mshr.sv
`timescale 1ns/100ps

module dcache_mshr #(
    parameter int MSHR_NUM = 4
) (
    input  logic                  clock,
    input  logic                  reset,
    input  dcache_pkg::lsq_req_t  req,
    input  logic                  miss,
    input  logic                  accept,
    input  dcache_pkg::mem_resp_t mem_resp,
    input  logic                  victim_held,
    output dcache_pkg::fill_t     fill,
    output dcache_pkg::lsq_resp_t ready_entry,
    output logic                  busy
);

    dcache_pkg::mshr_state_t state_q    [MSHR_NUM];
    dcache_pkg::lsq_req_t    entry_q    [MSHR_NUM];
    dcache_pkg::mem_tag_t    resp_tag_q [MSHR_NUM];
    dcache_pkg::line_t       line_q     [MSHR_NUM];

    logic [MSHR_NUM-1:0] free_vec;
    logic [MSHR_NUM-1:0] ready_vec;
    logic [MSHR_NUM-1:0] done_vec;
    logic [MSHR_NUM-1:0] store_wait_vec;
    logic [MSHR_NUM-1:0] same_line_vec;
    logic [MSHR_NUM-1:0] alloc_gnt;
    logic [MSHR_NUM-1:0] ready_gnt;

    always_comb begin
        for (int i = 0; i < MSHR_NUM; i++) begin
            free_vec[i]       = state_q[i] == dcache_pkg::MSHR_INVALID;
            ready_vec[i]      = state_q[i] == dcache_pkg::MSHR_READY;
            done_vec[i]       = state_q[i] == dcache_pkg::MSHR_WAITING
                                && mem_resp.tag != '0 && resp_tag_q[i] == mem_resp.tag;
            store_wait_vec[i] = state_q[i] == dcache_pkg::MSHR_WAITING && !entry_q[i].is_load;
            same_line_vec[i]  = state_q[i] == dcache_pkg::MSHR_WAITING
                                && entry_q[i].address[31:3] == req.address[31:3];
        end
    end

    // lowest set bit wins
    assign alloc_gnt = free_vec & (~free_vec + 1'b1);
    assign ready_gnt = ready_vec & (~ready_vec + 1'b1);

    assign busy = (free_vec == '0) || victim_held || (|store_wait_vec)
                  || (miss && |same_line_vec);

    always_comb begin
        fill = '0;
        for (int i = 0; i < MSHR_NUM; i++) begin
            if (done_vec[i]) begin
                fill.valid = 1'b1;
                fill.index = entry_q[i].address[6:3];
                fill.tag   = entry_q[i].address[31:7];
                fill.data  = entry_q[i].is_load ? mem_resp.data :
                             dcache_pkg::store_merge(mem_resp.data, entry_q[i].value,
                                                     entry_q[i].size, entry_q[i].address[2:0]);
            end
        end
    end

    always_comb begin
        ready_entry = '0;
        for (int i = 0; i < MSHR_NUM; i++) begin
            if (ready_gnt[i]) begin
                ready_entry.valid   = 1'b1;
                ready_entry.address = entry_q[i].address;
                ready_entry.is_load = entry_q[i].is_load;
                ready_entry.lsq_tag = entry_q[i].lsq_tag;
                ready_entry.value   = entry_q[i].is_load ?
                    dcache_pkg::load_extract(line_q[i], entry_q[i].size,
                                             entry_q[i].address[2:0], entry_q[i].is_unsigned) :
                    entry_q[i].value;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < MSHR_NUM; i++) begin
                state_q[i] <= dcache_pkg::MSHR_INVALID;
            end
        end else begin
            for (int i = 0; i < MSHR_NUM; i++) begin
                if (accept && miss && alloc_gnt[i]) begin
                    state_q[i] <= dcache_pkg::MSHR_WAITING;
                end else if (done_vec[i]) begin
                    state_q[i] <= dcache_pkg::MSHR_READY;
                end else if (ready_gnt[i]) begin
                    state_q[i] <= dcache_pkg::MSHR_INVALID;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        for (int i = 0; i < MSHR_NUM; i++) begin
            if (accept && miss && alloc_gnt[i]) begin
                entry_q[i]    <= req;
                resp_tag_q[i] <= mem_resp.response;
            end
            if (done_vec[i]) begin
                line_q[i] <= fill.data;
            end
        end
    end

    // memory hands out each response tag to one fetch at a time
    a_one_completion: assert property (@(posedge clock) disable iff (reset)
        $onehot0(done_vec));

endmodule

// File: verilog/dcache_mem_port.sv
`timescale 1ns/100ps

module dcache_mem_port (
    input  logic                 miss_fetch,
    input  dcache_pkg::addr_t    address,
    input  dcache_pkg::victim_t  victim,
    output dcache_pkg::mem_req_t mem_req,
    output logic                 victim_taken
);

    always_comb begin
        mem_req.command = dcache_pkg::CMD_NONE;
        mem_req.address = '0;
        mem_req.data    = '0;
        victim_taken    = 1'b0;
        if (miss_fetch) begin
            mem_req.command = dcache_pkg::CMD_LOAD;
            mem_req.address = {address[31:3], 3'b000};
        end else if (victim.valid) begin
            mem_req.command = dcache_pkg::CMD_STORE;
            mem_req.address = victim.address;
            mem_req.data    = victim.data;
            victim_taken    = 1'b1;
        end
    end

    // busy holds off new misses while a write-back is pending
    always_comb begin
        a_no_fetch_on_victim: assert final (!(miss_fetch && victim.valid));
    end

endmodule

// File: verilog/dcache_respond.sv
`timescale 1ns/100ps

module dcache_respond (
    input  logic                  clock,
    input  logic                  reset,
    input  dcache_pkg::lsq_req_t  req,
    input  logic                  hit,
    input  dcache_pkg::line_t     line,
    input  dcache_pkg::lsq_resp_t ready_entry,
    output dcache_pkg::lsq_resp_t hit_resp,
    output dcache_pkg::lsq_resp_t miss_resp
);

    always_ff @(posedge clock) begin
        if (reset) begin
            hit_resp.valid  <= 1'b0;
            miss_resp.valid <= 1'b0;
        end else begin
            hit_resp.valid   <= hit;
            hit_resp.address <= req.address;
            hit_resp.is_load <= req.is_load;
            hit_resp.lsq_tag <= req.lsq_tag;
            // stores echo their own value
            hit_resp.value   <= req.is_load ?
                dcache_pkg::load_extract(line, req.size, req.address[2:0], req.is_unsigned) :
                req.value;
            miss_resp        <= ready_entry;
        end
    end

endmodule

// File: verilog/dcache.sv
`timescale 1ns/100ps

module dcache #(
    parameter int MSHR_NUM = 4
) (
    input  logic                  clock,
    input  logic                  reset,
    input  dcache_pkg::lsq_req_t  req,
    output logic                  busy,
    output dcache_pkg::lsq_resp_t hit_resp,
    output dcache_pkg::lsq_resp_t miss_resp,
    output dcache_pkg::mem_req_t  mem_req,
    input  dcache_pkg::mem_resp_t mem_resp
);

    dcache_pkg::set_idx_t   index;
    dcache_pkg::cache_set_t set_data;
    dcache_pkg::fill_t      fill;
    dcache_pkg::victim_t    victim;
    dcache_pkg::lsq_resp_t  ready_entry;
    dcache_pkg::line_t      hit_line;
    logic                   hit;
    logic                   hit_way;
    logic                   miss;
    logic                   victim_taken;
    logic                   accept;
    logic                   hit_accept;
    logic                   miss_fetch;

    assign accept     = req.valid && !busy;
    assign hit_accept = hit && accept;
    assign miss_fetch = miss && accept;
    assign hit_line   = set_data.way[hit_way].data;

    dcache_lookup u_lookup (
        .req      (req),
        .set_data (set_data),
        .index    (index),
        .hit      (hit),
        .hit_way  (hit_way),
        .miss     (miss)
    );

    dcache_array u_array (
        .clock        (clock),
        .reset        (reset),
        .req          (req),
        .index        (index),
        .hit          (hit_accept),
        .hit_way      (hit_way),
        .fill         (fill),
        .set_data     (set_data),
        .victim       (victim),
        .victim_taken (victim_taken)
    );

    dcache_mshr #(
        .MSHR_NUM (MSHR_NUM)
    ) u_mshr (
        .clock       (clock),
        .reset       (reset),
        .req         (req),
        .miss        (miss),
        .accept      (accept),
        .mem_resp    (mem_resp),
        .victim_held (victim.valid),
        .fill        (fill),
        .ready_entry (ready_entry),
        .busy        (busy)
    );

    dcache_mem_port u_mem_port (
        .miss_fetch   (miss_fetch),
        .address      (req.address),
        .victim       (victim),
        .mem_req      (mem_req),
        .victim_taken (victim_taken)
    );

    dcache_respond u_respond (
        .clock       (clock),
        .reset       (reset),
        .req         (req),
        .hit         (hit_accept),
        .line        (hit_line),
        .ready_entry (ready_entry),
        .hit_resp    (hit_resp),
        .miss_resp   (miss_resp)
    );

endmodule

// File: sim/dcache_mem_model.sv
`timescale 1ns/100ps

module dcache_mem_model (
    input  logic                  clock,
    input  logic                  reset,
    input  dcache_pkg::mem_req_t  mem_req,
    output dcache_pkg::mem_resp_t mem_resp
);

    dcache_pkg::line_t    store [dcache_pkg::addr_t];
    // write-backs seen, checked by the testbench
    dcache_pkg::addr_t    store_addr_log [$];
    dcache_pkg::line_t    store_data_log [$];

    logic [15:0]          pend;
    dcache_pkg::addr_t    pend_addr [16];
    int                   countdown [16];
    dcache_pkg::mem_tag_t free_tag;
    dcache_pkg::mem_tag_t done_tag;
    dcache_pkg::line_t    done_data;
    logic [7:0]           lfsr;

    function automatic dcache_pkg::line_t backing_line(dcache_pkg::addr_t a);
        return store.exists(a) ? store[a] : {a ^ 32'h6b3c_91e5, ~a};
    endfunction

    always_comb begin
        free_tag = '0;
        for (int t = 15; t >= 1; t--) begin
            if (!pend[t] && done_tag != t) begin
                free_tag = t;
            end
        end
        mem_resp.response = (mem_req.command == dcache_pkg::CMD_LOAD) ? free_tag : '0;
        mem_resp.tag      = done_tag;
        mem_resp.data     = done_data;
    end

    always @(posedge clock) begin
        logic       found;
        logic [7:0] s;
        logic [2:0] extra;
        if (reset) begin
            pend     <= '0;
            done_tag <= '0;
            lfsr     <= 8'd62;
        end else begin
            found    = 1'b0;
            done_tag <= '0;
            for (int t = 1; t < 16; t++) begin
                if (pend[t] && countdown[t] != 0) begin
                    countdown[t] <= countdown[t] - 1;
                end else if (pend[t] && !found) begin
                    // one completion per cycle, in countdown order
                    found        = 1'b1;
                    done_tag     <= t;
                    done_data    <= backing_line(pend_addr[t]);
                    pend[t]      <= 1'b0;
                end
            end
            if (mem_req.command == dcache_pkg::CMD_LOAD) begin
                s = lfsr;
                for (int i = 0; i < 3; i++) begin
                    s        = {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
                    extra[i] = s[0];
                end
                lfsr                <= s;
                pend[free_tag]      <= 1'b1;
                pend_addr[free_tag] <= mem_req.address;
                countdown[free_tag] <= 8 + extra;
            end else if (mem_req.command == dcache_pkg::CMD_STORE) begin
                store[mem_req.address] = mem_req.data;
                store_addr_log.push_back(mem_req.address);
                store_data_log.push_back(mem_req.data);
            end
        end
    end

endmodule

// File: sim/dcache_tb.sv
`timescale 1ns/100ps

module dcache_tb;

    logic                  clock;
    logic                  reset;
    dcache_pkg::lsq_req_t  req;
    logic                  busy;
    dcache_pkg::lsq_resp_t hit_resp;
    dcache_pkg::lsq_resp_t miss_resp;
    dcache_pkg::mem_req_t  mem_req;
    dcache_pkg::mem_resp_t mem_resp;

    int                    errors = 0;
    logic [7:0]            lfsr = 8'd62;
    dcache_pkg::line_t     shadow [dcache_pkg::addr_t];
    dcache_pkg::lsq_resp_t miss_q [$];

    dcache #(.MSHR_NUM(4)) dut (
        .clock     (clock),
        .reset     (reset),
        .req       (req),
        .busy      (busy),
        .hit_resp  (hit_resp),
        .miss_resp (miss_resp),
        .mem_req   (mem_req),
        .mem_resp  (mem_resp)
    );

    dcache_mem_model mem (
        .clock    (clock),
        .reset    (reset),
        .mem_req  (mem_req),
        .mem_resp (mem_resp)
    );

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    // six tests at 200 cycles each, plus margin
    initial begin
        #((6 * 200 + 50) * 100);
        $display("watchdog expired before the tests finished");
        $display("Test failed");
        $finish;
    end

    always @(negedge clock) begin
        if (miss_resp.valid) begin
            miss_q.push_back(miss_resp);
        end
    end

    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
            r    = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic dcache_pkg::addr_t line_of(dcache_pkg::addr_t a);
        return {a[31:3], 3'b000};
    endfunction

    function automatic dcache_pkg::line_t ref_line(dcache_pkg::addr_t a);
        dcache_pkg::addr_t la;
        la = line_of(a);
        return shadow.exists(la) ? shadow[la] : {la ^ 32'h6b3c_91e5, ~la};
    endfunction

    // byte lanes, little endian within the line
    function automatic dcache_pkg::word_t expect_load(dcache_pkg::line_t line,
                                                      dcache_pkg::mem_size_t size,
                                                      logic [2:0] off, logic uns);
        logic [7:0] b [8];
        int         lo;
        for (int i = 0; i < 8; i++) begin
            b[i] = line[8*i +: 8];
        end
        case (size)
            dcache_pkg::BYTE: begin
                return uns ? {24'h0, b[off]} : {{24{b[off][7]}}, b[off]};
            end
            dcache_pkg::HALF: begin
                lo = {off[2:1], 1'b0};
                return uns ? {16'h0, b[lo+1], b[lo]} : {{16{b[lo+1][7]}}, b[lo+1], b[lo]};
            end
            default: begin
                lo = {off[2], 2'b00};
                return {b[lo+3], b[lo+2], b[lo+1], b[lo]};
            end
        endcase
    endfunction

    function automatic dcache_pkg::line_t expect_store(dcache_pkg::line_t line,
                                                       dcache_pkg::word_t v,
                                                       dcache_pkg::mem_size_t size,
                                                       logic [2:0] off);
        int start;
        int nbytes;
        start  = (size == dcache_pkg::BYTE) ? off :
                 (size == dcache_pkg::HALF) ? {off[2:1], 1'b0} : {off[2], 2'b00};
        nbytes = (size == dcache_pkg::BYTE) ? 1 : (size == dcache_pkg::HALF) ? 2 : 4;
        for (int i = 0; i < nbytes; i++) begin
            line[8*(start+i) +: 8] = v[8*i +: 8];
        end
        return line;
    endfunction

    function automatic logic [2:0] align(logic [2:0] off, dcache_pkg::mem_size_t size);
        if (size == dcache_pkg::HALF) return {off[2:1], 1'b0};
        if (size == dcache_pkg::WORD) return {off[2], 2'b00};
        return off;
    endfunction

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            errors++;
            $display("ERROR %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic send(input logic is_load, input dcache_pkg::addr_t a,
                        input dcache_pkg::mem_size_t size, input logic uns,
                        input dcache_pkg::word_t v, input dcache_pkg::lsq_tag_t tag,
                        output dcache_pkg::mem_cmd_t cmd, output dcache_pkg::addr_t cmd_addr);
        dcache_pkg::lsq_req_t r;
        int                   waited;
        r.valid       = 1'b1;
        r.address     = a;
        r.is_load     = is_load;
        r.size        = size;
        r.is_unsigned = uns;
        r.value       = v;
        r.lsq_tag     = tag;
        waited        = 0;
        @(posedge clock);
        req <= r;
        @(negedge clock);
        while (busy && waited < 200) begin
            @(negedge clock);
            waited++;
        end
        if (busy) begin
            errors++;
            $display("request to %h was never accepted, busy stayed high", a);
        end
        cmd      = dcache_pkg::mem_cmd_t'(mem_req.command);
        cmd_addr = mem_req.address;
        @(posedge clock);
        req <= '0;
    endtask

    task automatic wait_miss(input dcache_pkg::lsq_tag_t tag,
                             output dcache_pkg::lsq_resp_t r);
        int   waited;
        logic found;
        waited = 0;
        found  = 1'b0;
        r      = '0;
        while (!found && waited < 200) begin
            for (int i = 0; i < miss_q.size(); i++) begin
                if (!found && miss_q[i].lsq_tag == tag) begin
                    r     = miss_q[i];
                    found = 1'b1;
                    miss_q.delete(i);
                end
            end
            if (!found) begin
                @(negedge clock);
                waited++;
            end
        end
        if (!found) begin
            errors++;
            $display("no miss response arrived for queue tag %0d", tag);
        end
    endtask

    task automatic load_miss(input dcache_pkg::addr_t a, input dcache_pkg::mem_size_t size,
                             input logic uns, input dcache_pkg::lsq_tag_t tag);
        dcache_pkg::mem_cmd_t  cmd;
        dcache_pkg::addr_t     cmd_addr;
        dcache_pkg::lsq_resp_t r;
        send(1'b1, a, size, uns, '0, tag, cmd, cmd_addr);
        check("mem_req.command", cmd, dcache_pkg::CMD_LOAD);
        check("mem_req.address", cmd_addr, line_of(a));
        wait_miss(tag, r);
        check("miss_resp.address", r.address, a);
        check("miss_resp.is_load", r.is_load, 1'b1);
        check("miss_resp.value", r.value, expect_load(ref_line(a), size, a[2:0], uns));
    endtask

    task automatic load_hit(input dcache_pkg::addr_t a, input dcache_pkg::mem_size_t size,
                            input logic uns);
        dcache_pkg::mem_cmd_t cmd;
        dcache_pkg::addr_t    cmd_addr;
        send(1'b1, a, size, uns, '0, 4'd3, cmd, cmd_addr);
        @(negedge clock);
        check("hit_resp.valid", hit_resp.valid, 1'b1);
        check("hit_resp.address", hit_resp.address, a);
        check("hit_resp.lsq_tag", hit_resp.lsq_tag, 4'd3);
        check("hit_resp.value", hit_resp.value, expect_load(ref_line(a), size, a[2:0], uns));
    endtask

    task automatic store_hit(input dcache_pkg::addr_t a, input dcache_pkg::mem_size_t size,
                             input dcache_pkg::word_t v);
        dcache_pkg::mem_cmd_t cmd;
        dcache_pkg::addr_t    cmd_addr;
        send(1'b0, a, size, 1'b0, v, 4'd4, cmd, cmd_addr);
        @(negedge clock);
        check("hit_resp.valid", hit_resp.valid, 1'b1);
        check("hit_resp.is_load", hit_resp.is_load, 1'b0);
        check("hit_resp.lsq_tag", hit_resp.lsq_tag, 4'd4);
        shadow[line_of(a)] = expect_store(ref_line(a), v, size, a[2:0]);
    endtask

    dcache_pkg::addr_t first_addr;

    task automatic test_reset();
        check("busy", busy, 1'b0);
        check("hit_resp.valid", hit_resp.valid, 1'b0);
        check("miss_resp.valid", miss_resp.valid, 1'b0);
        check("mem_req.command", mem_req.command, dcache_pkg::CMD_NONE);
    endtask

    task automatic test_load_miss_hit();
        first_addr = {25'(rand_bits(25)), 4'd1, 3'(rand_bits(3))};
        load_miss(first_addr, dcache_pkg::BYTE, 1'b0, 4'd1);
        load_hit(first_addr, dcache_pkg::BYTE, 1'b0);
    endtask

    task automatic test_store_hits();
        dcache_pkg::mem_size_t size;
        dcache_pkg::addr_t     a;
        for (int k = 0; k < 8; k++) begin
            size = dcache_pkg::mem_size_t'(rand_bits(2) % 3);
            a    = {first_addr[31:3], align(3'(rand_bits(3)), size)};
            store_hit(a, size, rand_bits(32));
            load_hit(a, size, 1'b0);
            load_hit(a, size, 1'b1);
        end
        load_hit({first_addr[31:3], 3'd0}, dcache_pkg::WORD, 1'b0);
        load_hit({first_addr[31:3], 3'd4}, dcache_pkg::WORD, 1'b0);
    endtask

    task automatic test_store_miss();
        dcache_pkg::addr_t     a;
        dcache_pkg::word_t     v;
        dcache_pkg::mem_cmd_t  cmd;
        dcache_pkg::addr_t     cmd_addr;
        dcache_pkg::lsq_resp_t r;
        a = {25'(rand_bits(25)), 4'd2, 1'(rand_bits(1)), 2'b00};
        v = rand_bits(32);
        send(1'b0, a, dcache_pkg::WORD, 1'b0, v, 4'd5, cmd, cmd_addr);
        check("mem_req.command", cmd, dcache_pkg::CMD_LOAD);
        @(negedge clock);
        check("busy", busy, 1'b1);
        shadow[line_of(a)] = expect_store(ref_line(a), v, dcache_pkg::WORD, a[2:0]);
        wait_miss(4'd5, r);
        check("miss_resp.address", r.address, a);
        check("miss_resp.is_load", r.is_load, 1'b0);
        check("miss_resp.value", r.value, v);
        load_hit(a, dcache_pkg::WORD, 1'b0);
        load_hit(a ^ 32'h4, dcache_pkg::WORD, 1'b0);
    endtask

    task automatic test_eviction();
        dcache_pkg::addr_t t0;
        dcache_pkg::addr_t t1;
        dcache_pkg::addr_t t2;
        int                n;
        int                waited;
        t0 = {25'(rand_bits(25)), 4'd5, 3'd0};
        t1 = {25'(rand_bits(25)), 4'd5, 3'd4};
        t2 = {25'(rand_bits(25)), 4'd5, 3'd0};
        load_miss(t0, dcache_pkg::WORD, 1'b0, 4'd6);
        load_miss(t1, dcache_pkg::WORD, 1'b0, 4'd7);
        store_hit(t1, dcache_pkg::WORD, rand_bits(32));
        // t0 used last, so t1 is the victim
        load_hit(t0, dcache_pkg::WORD, 1'b0);
        n = mem.store_addr_log.size();
        load_miss(t2, dcache_pkg::WORD, 1'b0, 4'd8);
        waited = 0;
        while (mem.store_addr_log.size() == n && waited < 20) begin
            @(negedge clock);
            waited++;
        end
        if (mem.store_addr_log.size() == n) begin
            errors++;
            $display("no write-back of the evicted line reached memory");
        end else begin
            check("mem_req.address", mem.store_addr_log[n], line_of(t1));
            check("mem_req.data", mem.store_data_log[n], ref_line(t1));
        end
        load_miss(t1, dcache_pkg::WORD, 1'b0, 4'd9);
    endtask

    task automatic test_four_misses();
        dcache_pkg::addr_t     a [4];
        dcache_pkg::mem_size_t size [4];
        logic                  uns [4];
        dcache_pkg::mem_cmd_t  cmd;
        dcache_pkg::addr_t     cmd_addr;
        dcache_pkg::lsq_resp_t r;
        for (int i = 0; i < 4; i++) begin
            size[i] = dcache_pkg::mem_size_t'(rand_bits(2) % 3);
            uns[i]  = rand_bits(1);
            a[i]    = {25'(rand_bits(25)), 4'(8 + i), align(3'(rand_bits(3)), size[i])};
            send(1'b1, a[i], size[i], uns[i], '0, 4'(8 + i), cmd, cmd_addr);
            check("mem_req.command", cmd, dcache_pkg::CMD_LOAD);
        end
        @(negedge clock);
        check("busy", busy, 1'b1);
        for (int i = 0; i < 4; i++) begin
            wait_miss(4'(8 + i), r);
            check("miss_resp.address", r.address, a[i]);
            check("miss_resp.value", r.value,
                  expect_load(ref_line(a[i]), size[i], a[i][2:0], uns[i]));
        end
    endtask

    initial begin
        req   = '0;
        reset = 1'b1;
        repeat (2) @(posedge clock);
        reset <= 1'b0;
        @(negedge clock);
        test_reset();
        test_load_miss_hit();
        test_store_hits();
        test_store_miss();
        test_eviction();
        test_four_misses();
        repeat (4) @(posedge clock);
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: dcache.f
verilog/dcache_pkg.sv
verilog/dcache_lookup.sv
verilog/dcache_array.sv
verilog/dcache_mshr.sv
verilog/dcache_mem_port.sv
verilog/dcache_respond.sv
verilog/dcache.sv
sim/dcache_mem_model.sv
sim/dcache_tb.sv

// File: Bender.yml
package:
  name: dcache

sources:
  - verilog/dcache_pkg.sv
  - verilog/dcache_lookup.sv
  - verilog/dcache_array.sv
  - verilog/dcache_mshr.sv
  - verilog/dcache_mem_port.sv
  - verilog/dcache_respond.sv
  - verilog/dcache.sv
  - target: simulation
    files:
      - sim/dcache_mem_model.sv
      - sim/dcache_tb.sv
